// File: logic/audio_pkg.sv
package audio_pkg;

	// one audio sample, one byte on the serial line
	typedef logic [7:0] sample_t;

	// fifo occupancy, 0 up to and including the depth
	typedef logic [15:0] fill_t;

	// largest depth that fill_t has to represent
	localparam int MAX_FIFO_DEPTH = 16384;

	// divisor behind both fill thresholds
	localparam int ALMOST_DIV = 10;

	// at or below this fill the fifo counts as almost empty
	function automatic fill_t almost_empty_level(input int depth);
		int q;
		q = depth / ALMOST_DIV;
		return fill_t'(q);
	endfunction

	// at or above this fill the fifo counts as almost full
	function automatic fill_t almost_full_level(input int depth);
		int q;
		q = depth / ALMOST_DIV;
		return fill_t'(depth - 2 * q);
	endfunction

endpackage

// File: logic/uart_byte_rx.sv
module uart_byte_rx import audio_pkg::*; #(
	parameter int CLKS_PER_BIT = 104
) (
	input  logic    CLK_IN,
	input  logic    rst_n_i,
	input  logic    rx_i,
	output logic    byte_req_o,
	input  logic    byte_ack_i,
	output sample_t byte_data_o,
	output logic    overrun_o
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	sample_t shift;
	logic bit_done;
	logic stop_mid;
	logic hs_open;

	// two flops against metastability, third one for the edge
	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign bit_done = (state == RX_DATA) && (clk_cnt == BIT_LAST);
	assign stop_mid = (state == RX_STOP) && (clk_cnt == BIT_LAST);
	// previous byte not yet taken by the fifo
	assign hs_open = byte_req_o || byte_ack_i;

	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			byte_req_o <= 1'b0;
			overrun_o <= 1'b0;
		end else begin
			// requester side, drop req once ack is seen
			if (byte_req_o && byte_ack_i)
				byte_req_o <= 1'b0;

			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// line went high again, glitch
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (stop_mid) begin
						state <= RX_IDLE;
						// framing error when stop bit is low, byte dropped
						if (rx_sync) begin
							if (hs_open)
								overrun_o <= 1'b1;
							else
								byte_req_o <= 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge CLK_IN) begin
		if (bit_done)
			shift <= {rx_sync, shift[7:1]};
		if (stop_mid && rx_sync && !hs_open)
			byte_data_o <= shift;
	end

endmodule

// File: logic/sample_fifo.sv
module sample_fifo import audio_pkg::*; #(
	parameter int FIFO_DEPTH = 16384
) (
	input  logic    CLK_IN,
	input  logic    rst_n_i,
	input  logic    byte_req_i,
	output logic    byte_ack_o,
	input  sample_t byte_data_i,
	input  logic    pop_i,
	output sample_t head_o,
	output fill_t   fill_o,
	output logic    empty_o,
	output logic    full_o,
	output logic    almost_empty_o,
	output logic    almost_full_o
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam fill_t DEPTH_FILL = fill_t'(FIFO_DEPTH);
	localparam fill_t AE_LEVEL = almost_empty_level(FIFO_DEPTH);
	localparam fill_t AF_LEVEL = almost_full_level(FIFO_DEPTH);

	sample_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_write;
	logic do_read;

	// accept only a fresh request, never while ack is still up
	assign do_write = byte_req_i && !byte_ack_o && !full_o;
	assign do_read = pop_i && !empty_o;

	// handshake acknowledge, falls after req is gone
	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			byte_ack_o <= 1'b0;
		end else begin
			if (do_write)
				byte_ack_o <= 1'b1;
			else if (!byte_req_i)
				byte_ack_o <= 1'b0;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			fill_o <= '0;
		end else begin
			case ({do_write, do_read})
				2'b10: fill_o <= fill_o + 1'b1;
				2'b01: fill_o <= fill_o - 1'b1;
				default: fill_o <= fill_o;
			endcase
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (do_write)
			mem[wr_ptr] <= byte_data_i;
	end

	// head is the oldest sample, valid whenever not empty
	assign head_o = mem[rd_ptr];

	// all flags decode the registered count
	assign empty_o = (fill_o == '0);
	assign full_o = (fill_o == DEPTH_FILL);
	assign almost_empty_o = (fill_o <= AE_LEVEL);
	assign almost_full_o = (fill_o >= AF_LEVEL);

endmodule

// File: logic/sample_pacer.sv
module sample_pacer #(
	parameter int CLKS_PER_SAMPLE = 1088
) (
	input  logic CLK_IN,
	input  logic rst_n_i,
	output logic tick_o
);

	localparam int CNT_W = $clog2(CLKS_PER_SAMPLE);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_SAMPLE - 1);

	logic [CNT_W-1:0] cnt;

	// count down, reload after reaching zero
	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			cnt <= RELOAD;
		end else begin
			if (cnt == '0)
				cnt <= RELOAD;
			else
				cnt <= cnt - 1'b1;
		end
	end

	// one cycle strobe per sample period
	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i)
			tick_o <= 1'b0;
		else
			tick_o <= (cnt == '0);
	end

endmodule

// File: logic/sigma_delta_dac.sv
module sigma_delta_dac import audio_pkg::*; (
	input  logic    CLK_IN,
	input  logic    rst_n_i,
	input  logic    update_i,
	input  logic    clear_i,
	input  sample_t level_i,
	output logic    pdm_o
);

	sample_t acc;
	logic [8:0] sum;

	// the carry out of the sum is the next output bit
	assign sum = {1'b0, acc} + {1'b0, level_i};

	always_ff @(posedge CLK_IN) begin
		if (!rst_n_i) begin
			acc <= '0;
			pdm_o <= 1'b0;
		end else if (clear_i) begin
			// nothing to play, hold silent
			acc <= '0;
			pdm_o <= 1'b0;
		end else if (update_i) begin
			acc <= sum[7:0];
			pdm_o <= sum[8];
		end
	end

	// density of ones on pdm_o is level_i / 256 per update

endmodule

// File: logic/uart_audio_player.sv
module uart_audio_player import audio_pkg::*; #(
	parameter int CLKS_PER_BIT = 104,
	parameter int CLKS_PER_SAMPLE = 1088,
	parameter int FIFO_DEPTH = 16384
) (
	input  logic       CLK_IN,
	input  logic       rst_n_i,
	input  logic       uart_rx_i,
	output logic       uart_cts_o,
	output logic       uart_dsr_o,
	output logic       audio_o,
	output logic [7:0] level_o,
	output logic       fifo_empty_o,
	output logic       fifo_full_o,
	output logic       almost_empty_o,
	output logic       almost_full_o,
	output logic       overrun_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic byte_req;
	logic byte_ack;
	sample_t byte_data;
	sample_t head;
	fill_t fill;
	fill_t fill_shift;
	logic tick;

	uart_byte_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_rx (
		.CLK_IN(CLK_IN),
		.rst_n_i(rst_n_i),
		.rx_i(uart_rx_i),
		.byte_req_o(byte_req),
		.byte_ack_i(byte_ack),
		.byte_data_o(byte_data),
		.overrun_o(overrun_o)
	);

	sample_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.CLK_IN(CLK_IN),
		.rst_n_i(rst_n_i),
		.byte_req_i(byte_req),
		.byte_ack_o(byte_ack),
		.byte_data_i(byte_data),
		.pop_i(tick),
		.head_o(head),
		.fill_o(fill),
		.empty_o(fifo_empty_o),
		.full_o(fifo_full_o),
		.almost_empty_o(almost_empty_o),
		.almost_full_o(almost_full_o)
	);

	sample_pacer #(
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE)
	) u_pacer (
		.CLK_IN(CLK_IN),
		.rst_n_i(rst_n_i),
		.tick_o(tick)
	);

	// dac takes the current head on the same tick that pops it
	sigma_delta_dac u_dac (
		.CLK_IN(CLK_IN),
		.rst_n_i(rst_n_i),
		.update_i(tick),
		.clear_i(fifo_empty_o),
		.level_i(head),
		.pdm_o(audio_o)
	);

	// modem lines follow the fill thresholds
	assign uart_cts_o = ~almost_empty_o;
	assign uart_dsr_o = ~almost_full_o;

	// fill bit AW lands on bit 15, the eight bits below it go out
	assign fill_shift = fill << (15 - AW);
	assign level_o = fill_shift[14:7];

endmodule

// File: sim/tb_uart_audio_player.sv
module tb_uart_audio_player import audio_pkg::*; #(
	parameter int CLKS_PER_BIT = 8,
	parameter int CLKS_PER_SAMPLE = 128,
	parameter int FIFO_DEPTH = 32
);

	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
	localparam int AE_FILL = FIFO_DEPTH / ALMOST_DIV;
	localparam int AF_FILL = FIFO_DEPTH - 2 * AE_FILL;
	localparam int QUIET_CLKS = 500;
	localparam int RAND_FRAMES = 40;
	localparam int DENSITY_BYTES = 96;
	localparam int LEAD_PERIODS = 16;
	localparam int WINDOW_PERIODS = 64;
	localparam int MAX_FILL_FRAMES = 200;
	localparam int MAX_OVERRUN_FRAMES = 16;
	localparam int HOLD_FRAMES = 4;
	localparam int DRAIN_CLKS = (FIFO_DEPTH + 1) * CLKS_PER_SAMPLE + 2;
	// every test back to back, worst case lengths
	localparam int TEST_CLKS = 8 * 4 + 2 * QUIET_CLKS + RAND_FRAMES * (FRAME_CLKS + 16)
		+ 2 * (DENSITY_BYTES * FRAME_CLKS + (LEAD_PERIODS + WINDOW_PERIODS) * CLKS_PER_SAMPLE)
		+ (MAX_FILL_FRAMES + MAX_OVERRUN_FRAMES + HOLD_FRAMES) * FRAME_CLKS + DRAIN_CLKS;
	localparam int WATCH_CLKS = 2 * TEST_CLKS;

	logic CLK_IN = 1'b0;
	logic rst_n_i;
	logic uart_rx_i;
	logic uart_cts_o;
	logic uart_dsr_o;
	logic audio_o;
	logic [7:0] level_o;
	logic fifo_empty_o;
	logic fifo_full_o;
	logic almost_empty_o;
	logic almost_full_o;
	logic overrun_o;

	logic monitor_on;
	int full_count = 0;
	logic [31:0] rng_state = 32'h82ff_fe1e;

	uart_audio_player #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.CLK_IN(CLK_IN),
		.rst_n_i(rst_n_i),
		.uart_rx_i(uart_rx_i),
		.uart_cts_o(uart_cts_o),
		.uart_dsr_o(uart_dsr_o),
		.audio_o(audio_o),
		.level_o(level_o),
		.fifo_empty_o(fifo_empty_o),
		.fifo_full_o(fifo_full_o),
		.almost_empty_o(almost_empty_o),
		.almost_full_o(almost_full_o),
		.overrun_o(overrun_o)
	);

	always #4 CLK_IN = ~CLK_IN;

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_with($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			fail_with($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_near(input string name, input int got, input int exp, input int tol);
		if (got < exp - tol || got > exp + tol) begin
			fail_with($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h within %0d",
				name, got, exp, tol));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic sample_t next_sample();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	// level output is the fill scaled to 256 steps per depth, top bit dropped
	function automatic sample_t level_of(input int fill);
		return sample_t'(((fill % FIFO_DEPTH) * 256) / FIFO_DEPTH);
	endfunction

	task automatic apply_reset();
		@(negedge CLK_IN);
		rst_n_i = 1'b0;
		uart_rx_i = 1'b1;
		repeat (3) @(negedge CLK_IN);
		rst_n_i = 1'b1;
	endtask

	// one 8N1 frame, lsb first, starts and ends on a falling edge
	task automatic send_byte(input sample_t b);
		uart_rx_i = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge CLK_IN);
		for (int i = 0; i < 8; i++) begin
			uart_rx_i = b[i];
			repeat (CLKS_PER_BIT) @(negedge CLK_IN);
		end
		uart_rx_i = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge CLK_IN);
	endtask

	// flag rules that hold for any fill
	always @(negedge CLK_IN) begin
		if (monitor_on) begin
			check_bit("uart_cts_o", uart_cts_o, ~almost_empty_o);
			check_bit("uart_dsr_o", uart_dsr_o, ~almost_full_o);
			check_bit("fifo_empty_o & fifo_full_o", fifo_empty_o & fifo_full_o, 1'b0);
			check_bit("almost_empty_o & almost_full_o", almost_empty_o & almost_full_o,
				AE_FILL >= AF_FILL);
			if (fifo_empty_o) begin
				check_bit("almost_empty_o", almost_empty_o, 1'b1);
				check_sample("level_o", level_o, level_of(0));
			end
			if (fifo_full_o) begin
				check_bit("almost_full_o", almost_full_o, 1'b1);
				check_sample("level_o", level_o, level_of(FIFO_DEPTH));
				full_count++;
			end
		end
	end

	task automatic reset_state_test();
		apply_reset();
		check_bit("fifo_empty_o", fifo_empty_o, 1'b1);
		check_bit("almost_empty_o", almost_empty_o, 1'b1);
		check_bit("fifo_full_o", fifo_full_o, 1'b0);
		check_bit("almost_full_o", almost_full_o, 1'b0);
		check_bit("overrun_o", overrun_o, 1'b0);
		check_bit("uart_cts_o", uart_cts_o, 1'b0);
		check_bit("uart_dsr_o", uart_dsr_o, 1'b1);
		check_sample("level_o", level_o, level_of(0));
		repeat (QUIET_CLKS) begin
			@(negedge CLK_IN);
			check_bit("audio_o", audio_o, 1'b0);
		end
	endtask

	// first falling edge of empty means a fill of exactly one
	task automatic wait_first_sample();
		int waited;
		waited = 0;
		while (fifo_empty_o && waited < 2 * FRAME_CLKS) begin
			@(negedge CLK_IN);
			waited++;
		end
		if (fifo_empty_o)
			fail_with("first received byte never reached the FIFO");
		check_sample("level_o", level_o, level_of(1));
	endtask

	task automatic flag_stream_test();
		sample_t gap;
		apply_reset();
		fork
			send_byte(next_sample());
			wait_first_sample();
		join
		for (int i = 1; i < RAND_FRAMES; i++) begin
			send_byte(next_sample());
			gap = next_sample() & 8'h0f;
			repeat (gap) @(negedge CLK_IN);
		end
	endtask

	// ones per window follow level * updates / 256
	task automatic density_test(input sample_t value);
		int high_clks;
		int exp_periods;
		apply_reset();
		high_clks = 0;
		exp_periods = WINDOW_PERIODS * int'(value) / 256;
		fork
			begin
				repeat (DENSITY_BYTES) send_byte(value);
			end
			begin
				repeat (LEAD_PERIODS * CLKS_PER_SAMPLE) @(negedge CLK_IN);
				repeat (WINDOW_PERIODS * CLKS_PER_SAMPLE) begin
					@(negedge CLK_IN);
					if (audio_o)
						high_clks++;
				end
			end
		join
		check_near("audio_o high periods",
			(high_clks + CLKS_PER_SAMPLE / 2) / CLKS_PER_SAMPLE, exp_periods, 2);
	endtask

	task automatic fill_overrun_test();
		int frames;
		int start_count;
		apply_reset();
		start_count = full_count;
		frames = 0;
		while (full_count == start_count && frames < MAX_FILL_FRAMES) begin
			send_byte(next_sample());
			if (full_count == start_count)
				check_bit("overrun_o", overrun_o, 1'b0);
			frames++;
		end
		if (full_count == start_count)
			fail_with("FIFO never reported full under back-to-back frames");
		frames = 0;
		while (!overrun_o && frames < MAX_OVERRUN_FRAMES) begin
			send_byte(next_sample());
			frames++;
		end
		if (!overrun_o)
			fail_with("overrun_o did not rise while the FIFO stayed full");
		repeat (HOLD_FRAMES) begin
			send_byte(next_sample());
			check_bit("overrun_o", overrun_o, 1'b1);
		end
	endtask

	task automatic drain_test();
		int waited;
		waited = 0;
		while (!fifo_empty_o && waited < DRAIN_CLKS) begin
			@(negedge CLK_IN);
			waited++;
		end
		if (!fifo_empty_o)
			fail_with("FIFO did not drain within depth plus one sample periods");
		// last update may still be on the pin for one cycle
		@(negedge CLK_IN);
		repeat (QUIET_CLKS) begin
			@(negedge CLK_IN);
			check_bit("audio_o", audio_o, 1'b0);
			check_bit("fifo_empty_o", fifo_empty_o, 1'b1);
		end
		check_bit("overrun_o", overrun_o, 1'b1);
		apply_reset();
		check_bit("overrun_o", overrun_o, 1'b0);
	endtask

	initial begin
		repeat (WATCH_CLKS) @(posedge CLK_IN);
		fail_with("watchdog expired before the tests completed");
	end

	initial begin
		rst_n_i = 1'b0;
		uart_rx_i = 1'b1;
		monitor_on = 1'b0;
		apply_reset();
		monitor_on = 1'b1;
		reset_state_test();
		flag_stream_test();
		density_test(8'h40);
		density_test(8'hc0);
		fill_overrun_test();
		drain_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: uart_audio_player.f
logic/audio_pkg.sv
logic/uart_byte_rx.sv
logic/sample_fifo.sv
logic/sample_pacer.sv
logic/sigma_delta_dac.sv
logic/uart_audio_player.sv
sim/tb_uart_audio_player.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it, exit status follows the run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	-f uart_audio_player.f \
	--top-module tb_uart_audio_player \
	-Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vtb_uart_audio_player
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished with status 0"
exit 0
